/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/access_latency_timer.sv
      - src/store_mask_gen.sv
      - src/load_align.sv
      - src/mem_access_ctrl.sv
      - src/sram_axi_slave.sv
      - src/mem_stage.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/mem_stage_tb.sv

/* bench/mem_stage_tb.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module mem_stage_tb;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    // Fill, word, partial, pass-through, back-pressure and range transactions
    localparam int N_TXN = 256 + 32 + 48 + 16 + 24 + 32;

    logic               clk;
    logic               rst;
    logic               ex_valid_i;
    logic               ex_ready_o;
    lsu_pkg::word_t     pc_i;
    lsu_pkg::word_t     inst_i;
    lsu_pkg::word_t     result_i;
    lsu_pkg::word_t     addr_i;
    lsu_pkg::word_t     rs2_data_i;
    lsu_pkg::reg_addr_t rd_addr_i;
    logic               wb_valid_o;
    logic               wb_ready_i;
    lsu_pkg::word_t     pc_o;
    lsu_pkg::word_t     inst_o;
    lsu_pkg::word_t     result_o;
    lsu_pkg::word_t     load_data_o;
    lsu_pkg::reg_addr_t rd_addr_o;
    logic               access_err_o;

    logic [31:0]        lfsr;
    logic [7:0]         ref_mem [4*`LSU_DMEM_WORDS];
    int                 issued;
    int                 retired;
    int                 errors;
    int                 test_errors;
    int                 tests;
    logic               stall_en;
    logic               retire;
    // Expected write-back values of the instruction in flight
    lsu_pkg::word_t     exp_pc;
    lsu_pkg::word_t     exp_inst;
    lsu_pkg::word_t     exp_result;
    lsu_pkg::word_t     exp_load;
    lsu_pkg::reg_addr_t exp_rd;
    logic               exp_err;
    logic               chk_load;

    mem_stage mem_stage_inst (
        .clk(clk), .rst(rst),
        .ex_valid_i(ex_valid_i), .ex_ready_o(ex_ready_o),
        .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i),
        .addr_i(addr_i), .rs2_data_i(rs2_data_i), .rd_addr_i(rd_addr_i),
        .wb_valid_o(wb_valid_o), .wb_ready_i(wb_ready_i),
        .pc_o(pc_o), .inst_o(inst_o), .result_o(result_o),
        .load_data_o(load_data_o), .rd_addr_o(rd_addr_o), .access_err_o(access_err_o)
    );

    always #5 clk = ~clk;

    assign retire = wb_valid_o && wb_ready_i;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            retired <= 0;
        end else if (retire) begin
            retired <= retired + 1;
        end
    end

    task automatic report_mismatch(input string name, input lsu_pkg::word_t exp,
                                   input lsu_pkg::word_t act);
        $display("mismatch %s expected %h actual %h", name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    // Galois LFSR, one step per bit taken
    function automatic lsu_pkg::word_t take_bits(input int n);
        lsu_pkg::word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic lsu_pkg::funct3_t pick_load_size();
        case (take_bits(2))
            0: return lsu_pkg::FUNCT3_B;
            1: return lsu_pkg::FUNCT3_BU;
            2: return lsu_pkg::FUNCT3_H;
            default: return lsu_pkg::FUNCT3_HU;
        endcase
    endfunction

    // Aligned byte offset inside a word for the given size
    function automatic lsu_pkg::word_t lane_offset(input lsu_pkg::funct3_t f3);
        case (f3)
            lsu_pkg::FUNCT3_B, lsu_pkg::FUNCT3_BU: return take_bits(2);
            lsu_pkg::FUNCT3_H, lsu_pkg::FUNCT3_HU: return take_bits(1) << 1;
            default: return '0;
        endcase
    endfunction

    function automatic void model_store(input lsu_pkg::word_t addr, input lsu_pkg::funct3_t f3,
                                        input lsu_pkg::word_t data);
        int b;
        int n;
        b = int'(addr[`LSU_DMEM_AW+1:0]);
        n = (f3 == lsu_pkg::FUNCT3_B) ? 1 : (f3 == lsu_pkg::FUNCT3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[b + i] = data[8*i +: 8];
        end
    endfunction

    function automatic lsu_pkg::word_t model_load(input lsu_pkg::word_t addr,
                                                  input lsu_pkg::funct3_t f3);
        int b;
        b = int'(addr[`LSU_DMEM_AW+1:0]);
        case (f3)
            lsu_pkg::FUNCT3_B:  return {{24{ref_mem[b][7]}}, ref_mem[b]};
            lsu_pkg::FUNCT3_BU: return {24'd0, ref_mem[b]};
            lsu_pkg::FUNCT3_H:  return {{16{ref_mem[b+1][7]}}, ref_mem[b+1], ref_mem[b]};
            lsu_pkg::FUNCT3_HU: return {16'd0, ref_mem[b+1], ref_mem[b]};
            default: return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
        endcase
    endfunction

    // Send one instruction, then wait until it retires
    task automatic issue(input logic [6:0] op, input lsu_pkg::funct3_t f3,
                         input lsu_pkg::word_t addr, input lsu_pkg::word_t data);
        lsu_pkg::word_t upper;
        logic           in_range;
        upper      = take_bits(17);
        exp_rd     = lsu_pkg::reg_addr_t'(take_bits(`LSU_REG_ADDR_W));
        exp_inst   = {upper[16:0], f3, exp_rd, op};
        exp_pc     = take_bits(32) & ~32'h3;
        exp_result = take_bits(32);
        in_range   = addr[31:2] < `LSU_DMEM_WORDS;
        exp_err    = (op == lsu_pkg::OPCODE_LOAD || op == lsu_pkg::OPCODE_STORE) && !in_range;
        chk_load   = op == lsu_pkg::OPCODE_LOAD;
        exp_load   = (chk_load && in_range) ? model_load(addr, f3) : '0;
        if (op == lsu_pkg::OPCODE_STORE && in_range) begin
            model_store(addr, f3, data);
        end
        while (!ex_ready_o) begin
            @(posedge clk);
            #1;
        end
        ex_valid_i = 1'b1;
        pc_i       = exp_pc;
        inst_i     = exp_inst;
        result_i   = exp_result;
        addr_i     = addr;
        rs2_data_i = data;
        rd_addr_i  = exp_rd;
        @(posedge clk);
        #1;
        ex_valid_i = 1'b0;
        issued++;
        while (retired != issued) begin
            // Ready one cycle in four gives stall stretches
            wb_ready_i = stall_en ? (take_bits(2) == 0) : 1'b1;
            @(posedge clk);
            #1;
        end
        wb_ready_i = 1'b1;
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
        tests++;
    endtask

    a_pc: assert property (@(posedge clk) disable iff (rst) retire |-> pc_o == exp_pc)
        else report_mismatch("pc_o", $sampled(exp_pc), $sampled(pc_o));
    a_inst: assert property (@(posedge clk) disable iff (rst) retire |-> inst_o == exp_inst)
        else report_mismatch("inst_o", $sampled(exp_inst), $sampled(inst_o));
    a_result: assert property (@(posedge clk) disable iff (rst)
        retire |-> result_o == exp_result)
        else report_mismatch("result_o", $sampled(exp_result), $sampled(result_o));
    a_rd: assert property (@(posedge clk) disable iff (rst) retire |-> rd_addr_o == exp_rd)
        else report_mismatch("rd_addr_o", $sampled(exp_rd), $sampled(rd_addr_o));
    a_err: assert property (@(posedge clk) disable iff (rst)
        retire |-> access_err_o == exp_err)
        else report_mismatch("access_err_o", $sampled(exp_err), $sampled(access_err_o));
    a_load: assert property (@(posedge clk) disable iff (rst)
        retire && chk_load |-> load_data_o == exp_load)
        else report_mismatch("load_data_o", $sampled(exp_load), $sampled(load_data_o));

    // Each accepted instruction retires exactly once
    a_once: assert property (@(posedge clk) disable iff (rst) retire |-> retired + 1 == issued)
        else report_failure("instruction retired without a matching issue");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(pc_o) && $stable(inst_o)
        && $stable(result_o) && $stable(load_data_o) && $stable(rd_addr_o)
        && $stable(access_err_o))
        else report_failure("write-back outputs changed while stalled");
    a_no_accept: assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> !ex_ready_o)
        else report_failure("ex_ready_o high while write-back is pending");

    initial begin
        repeat (N_TXN * (`LSU_MEM_LATENCY + 20) + 15) @(posedge clk);
        $display("timeout, transactions did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lsu_pkg::word_t   a;
        lsu_pkg::word_t   d;
        lsu_pkg::word_t   bad;
        lsu_pkg::funct3_t f3;
        clk         = 1'b0;
        rst         = 1'b1;
        ex_valid_i  = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        result_i    = '0;
        addr_i      = '0;
        rs2_data_i  = '0;
        rd_addr_i   = '0;
        wb_ready_i  = 1'b1;
        lfsr        = 32'd22;
        issued      = 0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        stall_en    = 1'b0;
        chk_load    = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (!wb_valid_o) else report_failure("wb_valid_o high after reset");
        assert (ex_ready_o) else report_failure("ex_ready_o low after reset");
        assert (pc_o == `LSU_RESET_PC) else report_mismatch("pc_o", `LSU_RESET_PC, pc_o);
        finish_test("reset");

        // Fill pattern built from the full byte address
        for (int i = 0; i < `LSU_DMEM_WORDS; i++) begin
            a = i << 2;
            issue(lsu_pkg::OPCODE_STORE, lsu_pkg::FUNCT3_W, a,
                  a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5);
        end
        finish_test("fill");

        for (int i = 0; i < 16; i++) begin
            a = take_bits(`LSU_DMEM_AW) << 2;
            issue(lsu_pkg::OPCODE_STORE, lsu_pkg::FUNCT3_W, a, take_bits(32));
            issue(lsu_pkg::OPCODE_LOAD, lsu_pkg::FUNCT3_W, a, '0);
        end
        finish_test("word");

        for (int i = 0; i < 16; i++) begin
            a  = take_bits(`LSU_DMEM_AW) << 2;
            f3 = (take_bits(1) != 0) ? lsu_pkg::FUNCT3_B : lsu_pkg::FUNCT3_H;
            issue(lsu_pkg::OPCODE_STORE, f3, a + lane_offset(f3), take_bits(32));
            issue(lsu_pkg::OPCODE_LOAD, lsu_pkg::FUNCT3_W, a, '0);
            f3 = pick_load_size();
            issue(lsu_pkg::OPCODE_LOAD, f3, a + lane_offset(f3), '0);
        end
        finish_test("partial");

        // Read back after each pass-through to show memory untouched
        for (int i = 0; i < 8; i++) begin
            a = take_bits(`LSU_DMEM_AW) << 2;
            issue((take_bits(1) != 0) ? OP_REG : OP_IMM, lsu_pkg::funct3_t'(take_bits(3)), a,
                  take_bits(32));
            issue(lsu_pkg::OPCODE_LOAD, lsu_pkg::FUNCT3_W, a, '0);
        end
        finish_test("pass_through");

        stall_en = 1'b1;
        for (int i = 0; i < 24; i++) begin
            a = take_bits(`LSU_DMEM_AW) << 2;
            case (take_bits(2))
                0: issue(lsu_pkg::OPCODE_STORE, lsu_pkg::FUNCT3_W, a, take_bits(32));
                1: issue(lsu_pkg::OPCODE_LOAD, lsu_pkg::FUNCT3_W, a, '0);
                2: issue(OP_IMM, lsu_pkg::funct3_t'(take_bits(3)), a, take_bits(32));
                default: begin
                    f3 = pick_load_size();
                    issue(lsu_pkg::OPCODE_LOAD, f3, a + lane_offset(f3), '0);
                end
            endcase
        end
        stall_en = 1'b0;
        finish_test("back_pressure");

        // Out-of-range address aliases the same word index as a
        for (int i = 0; i < 8; i++) begin
            a   = take_bits(`LSU_DMEM_AW) << 2;
            d   = take_bits(32);
            bad = a + ((take_bits(8) + 1) << (`LSU_DMEM_AW + 2));
            issue(lsu_pkg::OPCODE_STORE, lsu_pkg::FUNCT3_W, a, d);
            issue(lsu_pkg::OPCODE_STORE, lsu_pkg::FUNCT3_W, bad, ~d);
            f3 = pick_load_size();
            issue(lsu_pkg::OPCODE_LOAD, f3, bad + lane_offset(f3), '0);
            issue(lsu_pkg::OPCODE_LOAD, lsu_pkg::FUNCT3_W, a, '0);
        end
        finish_test("range_error");

        $display("tests %0d, transactions %0d, errors %0d", tests, issued, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/lsu_pkg.sv
src/access_latency_timer.sv
src/store_mask_gen.sv
src/load_align.sv
src/mem_access_ctrl.sv
src/sram_axi_slave.sv
src/mem_stage.sv
bench/mem_stage_tb.sv

/* src/access_latency_timer.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module access_latency_timer (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic busy_o,
    output logic expire_o
);

    localparam int CNT_W = $clog2(`LSU_MEM_LATENCY + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= CNT_W'(`LSU_MEM_LATENCY);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign busy_o   = count_q != '0;
    // High in the last cycle, count hits zero on the next edge
    assign expire_o = count_q == CNT_W'(1);

    // Restart mid-count would lose a response
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start_i |-> !busy_o);

endmodule

/* src/load_align.sv */
`timescale 1ns/100ps

module load_align (
    input  lsu_pkg::funct3_t funct3_i,
    input  logic [1:0]       addr_lo_i,
    input  lsu_pkg::word_t   rdata_i,
    output lsu_pkg::word_t   data_o
);

    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    lsu_pkg::word_t shifted;

    // Move the addressed byte down to lane 0
    assign shifted  = rdata_i >> {addr_lo_i, 3'b000};
    assign byte_sel = shifted[7:0];
    // Upper or lower halfword
    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (funct3_i)
            lsu_pkg::FUNCT3_B: begin
                data_o = {{24{byte_sel[7]}}, byte_sel};
            end
            lsu_pkg::FUNCT3_BU: begin
                data_o = {24'd0, byte_sel};
            end
            lsu_pkg::FUNCT3_H: begin
                data_o = {{16{half_sel[15]}}, half_sel};
            end
            lsu_pkg::FUNCT3_HU: begin
                data_o = {16'd0, half_sel};
            end
            default: begin
                // LW and anything else pass the word unchanged
                data_o = rdata_i;
            end
        endcase
    end

endmodule

/* src/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]       word_t;
    typedef logic [`LSU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`LSU_XLEN/8-1:0]     strb_t;
    typedef logic [2:0]                 funct3_t;
    typedef logic [1:0]                 resp_t;

    // Memory stage control FSM
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } ctrl_state_t;

    // RV32I major opcodes handled here
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Access size codes from funct3
    localparam funct3_t FUNCT3_B  = 3'b000;
    localparam funct3_t FUNCT3_H  = 3'b001;
    localparam funct3_t FUNCT3_W  = 3'b010;
    localparam funct3_t FUNCT3_BU = 3'b100;
    localparam funct3_t FUNCT3_HU = 3'b101;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* src/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath and address width
`define LSU_XLEN 32

// Register file index width
`define LSU_REG_ADDR_W 5

// Data memory depth in words
`define LSU_DMEM_WORDS 256

// Word index width into the data memory
`define LSU_DMEM_AW 8

// Cycles from request acceptance to response valid
// Must be at least 1
`define LSU_MEM_LATENCY 2

// Value of the pc register out of reset
`define LSU_RESET_PC 32'h8000_0000

`endif

/* src/mem_access_ctrl.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module mem_access_ctrl (
    input  logic               clk,
    input  logic               rst,
    // Upstream from execute
    input  logic               ex_valid_i,
    output logic               ex_ready_o,
    input  lsu_pkg::word_t     pc_i,
    input  lsu_pkg::word_t     inst_i,
    input  lsu_pkg::word_t     result_i,
    input  lsu_pkg::word_t     addr_i,
    input  lsu_pkg::word_t     rs2_data_i,
    input  lsu_pkg::reg_addr_t rd_addr_i,
    // Downstream to write-back
    output logic               wb_valid_o,
    input  logic               wb_ready_i,
    output lsu_pkg::word_t     pc_o,
    output lsu_pkg::word_t     inst_o,
    output lsu_pkg::word_t     result_o,
    output lsu_pkg::word_t     addr_o,
    output lsu_pkg::word_t     rs2_o,
    output lsu_pkg::reg_addr_t rd_addr_o,
    output lsu_pkg::funct3_t   funct3_o,
    output lsu_pkg::word_t     rdata_o,
    output logic               access_err_o,
    // From store_mask_gen
    input  lsu_pkg::strb_t     strb_i,
    input  lsu_pkg::word_t     wdata_i,
    // AXI4-Lite master
    output logic               awvalid_o,
    input  logic               awready_i,
    output lsu_pkg::word_t     awaddr_o,
    output logic               wvalid_o,
    input  logic               wready_i,
    output lsu_pkg::word_t     wdata_o,
    output lsu_pkg::strb_t     wstrb_o,
    input  logic               bvalid_i,
    output logic               bready_o,
    input  lsu_pkg::resp_t     bresp_i,
    output logic               arvalid_o,
    input  logic               arready_i,
    output lsu_pkg::word_t     araddr_o,
    input  logic               rvalid_i,
    output logic               rready_o,
    input  lsu_pkg::word_t     rdata_i,
    input  lsu_pkg::resp_t     rresp_i
);

    lsu_pkg::ctrl_state_t state_q;
    logic                 req_q;
    logic                 in_is_mem;
    logic                 is_load;
    logic                 is_store;
    logic                 aw_hs;
    logic                 ar_hs;
    logic                 b_hs;
    logic                 r_hs;

    // Incoming opcode picks the next state, held opcode picks the channel
    assign in_is_mem = (inst_i[6:0] == lsu_pkg::OPCODE_LOAD) ||
                       (inst_i[6:0] == lsu_pkg::OPCODE_STORE);
    assign is_load   = inst_o[6:0] == lsu_pkg::OPCODE_LOAD;
    assign is_store  = inst_o[6:0] == lsu_pkg::OPCODE_STORE;
    assign funct3_o  = inst_o[14:12];

    assign ex_ready_o = state_q == lsu_pkg::IDLE;
    assign wb_valid_o = state_q == lsu_pkg::DONE;

    // Address and data presented together on the write channels
    assign awvalid_o = req_q && is_store;
    assign wvalid_o  = req_q && is_store;
    assign arvalid_o = req_q && is_load;
    assign awaddr_o  = addr_o;
    assign araddr_o  = addr_o;
    assign wdata_o   = wdata_i;
    assign wstrb_o   = strb_i;
    assign bready_o  = state_q == lsu_pkg::ACCESS;
    assign rready_o  = state_q == lsu_pkg::ACCESS;

    assign aw_hs = awvalid_o && awready_i && wvalid_o && wready_i;
    assign ar_hs = arvalid_o && arready_i;
    assign b_hs  = bvalid_i && bready_o;
    assign r_hs  = rvalid_i && rready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= lsu_pkg::IDLE;
            req_q        <= 1'b0;
            pc_o         <= `LSU_RESET_PC;
            inst_o       <= '0;
            result_o     <= '0;
            addr_o       <= '0;
            rs2_o        <= '0;
            rd_addr_o    <= '0;
            rdata_o      <= '0;
            access_err_o <= 1'b0;
        end else begin
            case (state_q)
                lsu_pkg::IDLE: begin
                    if (ex_valid_i) begin
                        pc_o         <= pc_i;
                        inst_o       <= inst_i;
                        result_o     <= result_i;
                        // Address only matters for memory ops
                        addr_o       <= in_is_mem ? addr_i : '0;
                        rs2_o        <= rs2_data_i;
                        rd_addr_o    <= rd_addr_i;
                        rdata_o      <= '0;
                        access_err_o <= 1'b0;
                        if (in_is_mem) begin
                            state_q <= lsu_pkg::ACCESS;
                            req_q   <= 1'b1;
                        end else begin
                            state_q <= lsu_pkg::DONE;
                        end
                    end
                end
                lsu_pkg::ACCESS: begin
                    if (aw_hs || ar_hs) begin
                        req_q <= 1'b0;
                    end
                    if (b_hs) begin
                        access_err_o <= bresp_i != lsu_pkg::RESP_OKAY;
                        state_q      <= lsu_pkg::DONE;
                    end else if (r_hs) begin
                        rdata_o      <= rdata_i;
                        access_err_o <= rresp_i != lsu_pkg::RESP_OKAY;
                        state_q      <= lsu_pkg::DONE;
                    end
                end
                lsu_pkg::DONE: begin
                    if (wb_ready_i) begin
                        state_q <= lsu_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= lsu_pkg::IDLE;
                end
            endcase
        end
    end

    // Request flag must never outlive the access phase
    a_valid_in_access: assert property (@(posedge clk) disable iff (rst)
        (awvalid_o || wvalid_o || arvalid_o) |-> state_q == lsu_pkg::ACCESS);

    // Write-back payload frozen while stalled
    a_wb_stable: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(pc_o) && $stable(inst_o)
        && $stable(result_o) && $stable(rd_addr_o) && $stable(rdata_o)
        && $stable(access_err_o));

endmodule

/* src/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid_i,
    output logic               ex_ready_o,
    input  lsu_pkg::word_t     pc_i,
    input  lsu_pkg::word_t     inst_i,
    input  lsu_pkg::word_t     result_i,
    input  lsu_pkg::word_t     addr_i,
    input  lsu_pkg::word_t     rs2_data_i,
    input  lsu_pkg::reg_addr_t rd_addr_i,
    output logic               wb_valid_o,
    input  logic               wb_ready_i,
    output lsu_pkg::word_t     pc_o,
    output lsu_pkg::word_t     inst_o,
    output lsu_pkg::word_t     result_o,
    output lsu_pkg::word_t     load_data_o,
    output lsu_pkg::reg_addr_t rd_addr_o,
    output logic               access_err_o
);

    lsu_pkg::word_t   addr_q;
    lsu_pkg::word_t   rs2_q;
    lsu_pkg::funct3_t funct3;
    lsu_pkg::word_t   rdata_q;
    lsu_pkg::strb_t   st_strb;
    lsu_pkg::word_t   st_wdata;

    // AXI4-Lite bus between controller and SRAM
    logic           awvalid, awready, wvalid, wready, bvalid, bready;
    logic           arvalid, arready, rvalid, rready;
    lsu_pkg::word_t awaddr, wdata, araddr, rdata;
    lsu_pkg::strb_t wstrb;
    lsu_pkg::resp_t bresp, rresp;

    mem_access_ctrl ctrl_inst (
        .clk(clk), .rst(rst),
        .ex_valid_i(ex_valid_i), .ex_ready_o(ex_ready_o),
        .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i),
        .addr_i(addr_i), .rs2_data_i(rs2_data_i), .rd_addr_i(rd_addr_i),
        .wb_valid_o(wb_valid_o), .wb_ready_i(wb_ready_i),
        .pc_o(pc_o), .inst_o(inst_o), .result_o(result_o),
        .addr_o(addr_q), .rs2_o(rs2_q), .rd_addr_o(rd_addr_o),
        .funct3_o(funct3), .rdata_o(rdata_q), .access_err_o(access_err_o),
        .strb_i(st_strb), .wdata_i(st_wdata),
        .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp),
        .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr),
        .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rresp_i(rresp)
    );

    store_mask_gen store_inst (
        .funct3_i(funct3), .addr_lo_i(addr_q[1:0]), .rs2_i(rs2_q),
        .strb_o(st_strb), .wdata_o(st_wdata)
    );

    load_align load_inst (
        .funct3_i(funct3), .addr_lo_i(addr_q[1:0]), .rdata_i(rdata_q),
        .data_o(load_data_o)
    );

    sram_axi_slave sram_inst (
        .clk(clk), .rst(rst),
        .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
        .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
    );

endmodule

/* src/sram_axi_slave.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module sram_axi_slave (
    input  logic           clk,
    input  logic           rst,
    // Write address and data
    input  logic           awvalid_i,
    output logic           awready_o,
    input  lsu_pkg::word_t awaddr_i,
    input  logic           wvalid_i,
    output logic           wready_o,
    input  lsu_pkg::word_t wdata_i,
    input  lsu_pkg::strb_t wstrb_i,
    // Write response
    output logic           bvalid_o,
    input  logic           bready_i,
    output lsu_pkg::resp_t bresp_o,
    // Read address and data
    input  logic           arvalid_i,
    output logic           arready_o,
    input  lsu_pkg::word_t araddr_i,
    output logic           rvalid_o,
    input  logic           rready_i,
    output lsu_pkg::word_t rdata_o,
    output lsu_pkg::resp_t rresp_o
);

    lsu_pkg::word_t          mem [`LSU_DMEM_WORDS];
    logic                    pending_q;
    logic                    write_q;
    logic                    in_range_q;
    logic [`LSU_DMEM_AW-1:0] idx_q;
    lsu_pkg::word_t          wdata_q;
    lsu_pkg::strb_t          wstrb_q;
    lsu_pkg::word_t          req_addr;
    logic                    wr_accept;
    logic                    rd_accept;
    logic                    accept;
    logic                    timer_busy;
    logic                    timer_expire;

    // One request in flight at a time
    assign awready_o = !pending_q;
    assign wready_o  = !pending_q;
    assign arready_o = !pending_q;

    assign wr_accept = awvalid_i && wvalid_i && !pending_q;
    assign rd_accept = arvalid_i && !pending_q && !wr_accept;
    assign accept    = wr_accept || rd_accept;
    assign req_addr  = wr_accept ? awaddr_i : araddr_i;

    access_latency_timer timer_inst (
        .clk      (clk),
        .rst      (rst),
        .start_i  (accept),
        .busy_o   (timer_busy),
        .expire_o (timer_expire)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= 1'b0;
            write_q   <= 1'b0;
            bvalid_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            bresp_o   <= lsu_pkg::RESP_OKAY;
            rresp_o   <= lsu_pkg::RESP_OKAY;
        end else begin
            if (accept) begin
                pending_q <= 1'b1;
                write_q   <= wr_accept;
            end
            if (timer_expire) begin
                if (write_q) begin
                    bvalid_o <= 1'b1;
                    bresp_o  <= in_range_q ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
                end else begin
                    rvalid_o <= 1'b1;
                    rresp_o  <= in_range_q ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
                end
            end
            // Response retires the request
            if (bvalid_o && bready_i) begin
                bvalid_o  <= 1'b0;
                pending_q <= 1'b0;
            end
            if (rvalid_o && rready_i) begin
                rvalid_o  <= 1'b0;
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q      <= req_addr[`LSU_DMEM_AW+1:2];
            in_range_q <= req_addr[`LSU_XLEN-1:2] < `LSU_DMEM_WORDS;
            wdata_q    <= wdata_i;
            wstrb_q    <= wstrb_i;
        end
        if (timer_expire) begin
            // Out of range writes are dropped
            if (write_q && in_range_q) begin
                for (int i = 0; i < `LSU_XLEN/8; i++) begin
                    if (wstrb_q[i]) begin
                        mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
                    end
                end
            end
            rdata_o <= (!write_q && in_range_q) ? mem[idx_q] : '0;
        end
    end

    // Timer idle and no response outstanding when a request is taken
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        accept |-> !timer_busy && !bvalid_o && !rvalid_o);

endmodule

/* src/store_mask_gen.sv */
`timescale 1ns/100ps

module store_mask_gen (
    input  lsu_pkg::funct3_t funct3_i,
    input  logic [1:0]       addr_lo_i,
    input  lsu_pkg::word_t   rs2_i,
    output lsu_pkg::strb_t   strb_o,
    output lsu_pkg::word_t   wdata_o
);

    always_comb begin
        case (funct3_i)
            lsu_pkg::FUNCT3_B: begin
                strb_o  = 4'b0001 << addr_lo_i;
                // Low byte copied to every lane
                wdata_o = {4{rs2_i[7:0]}};
            end
            lsu_pkg::FUNCT3_H: begin
                strb_o  = 4'b0011 << addr_lo_i;
                wdata_o = {2{rs2_i[15:0]}};
            end
            lsu_pkg::FUNCT3_W: begin
                strb_o  = 4'b1111;
                wdata_o = rs2_i;
            end
            default: begin
                // Unused size codes write nothing
                strb_o  = 4'b0000;
                wdata_o = rs2_i;
            end
        endcase
    end

    // Halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        a_aligned: assert #0 (!((funct3_i == lsu_pkg::FUNCT3_H && addr_lo_i[0]) ||
                               (funct3_i == lsu_pkg::FUNCT3_W && addr_lo_i != 2'b00)))
            else $error("misaligned access funct3=%0d addr_lo=%0d", funct3_i, addr_lo_i);
    end

endmodule
